//--- compile.f
+incdir+source
source/cache_pkg.sv
source/cache_port.sv
source/mem_arbiter.sv
source/split_cache_top.sv
verification/tb_split_cache.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_split_cache -f compile.f

result=$(./obj_dir/Vtb_split_cache 2>&1 || true)
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -q "^Regression passed$"; then
    exit 0
fi
echo "Simulation did not report a pass."
exit 1

//--- source/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Word width of the CPU and of the memory words.
`define CACHE_WORD_W 16

// Address split of a 16-bit word address.
`define CACHE_TAG_W 11
`define CACHE_INDEX_W 3
`define CACHE_OFFSET_W 2

// Line geometry of one side.
`define CACHE_LINE_WORDS 4  // Words per line.
`define CACHE_LINES 8       // Direct-mapped lines per side.

// Port 0 is the instruction side, port 1 the data side.
`define CACHE_PORTS 2

`endif

//--- source/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0] word_t;
    typedef logic [`CACHE_TAG_W-1:0] tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

    // CPU word address, tag in the upper bits.
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } cache_addr_t;

    // Word 0 sits in the most significant bits.
    typedef word_t [0:`CACHE_LINE_WORDS-1] line_t;

    typedef struct packed {
        tag_t   tag;
        index_t index;
    } line_addr_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef struct packed {
        logic       valid;
        mem_op_e    op;
        line_addr_t line_addr;
        line_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        line_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic        read;
        logic        write;
        cache_addr_t addr;
        word_t       wdata;
    } cpu_req_t;

    typedef enum logic [1:0] {
        PS_LOOKUP    = 2'd0,
        PS_WRITEBACK = 2'd1,
        PS_REFILL    = 2'd2
    } port_state_e;

endpackage

//--- source/cache_port.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_port import cache_pkg::*; (
    input  logic     Clk,
    input  logic     i_rst_n,
    input  cpu_req_t i_cpu_req,
    output word_t    o_cpu_rdata,
    output logic     o_cpu_done,
    output mem_req_t o_mem_req,
    input  mem_rsp_t i_mem_rsp
);

    tag_t                    tag_q  [`CACHE_LINES];
    line_t                   data_q [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;
    logic [`CACHE_LINES-1:0] dirty_q;

    port_state_e state_q;
    port_state_e state_d;

    index_t  index;
    tag_t    tag;
    offset_t offset;
    logic    cpu_active;
    logic    lookup_go;
    logic    hit;
    logic    victim_dirty;
    logic    wb_done;
    logic    refill_done;

    assign index  = i_cpu_req.addr.index;
    assign tag    = i_cpu_req.addr.tag;
    assign offset = i_cpu_req.addr.offset;

    // The request is still held during the done cycle, so skip it there.
    assign cpu_active = (i_cpu_req.read || i_cpu_req.write) && !o_cpu_done;
    assign lookup_go  = (state_q == PS_LOOKUP) && cpu_active;

    assign hit          = valid_q[index] && (tag_q[index] == tag);
    assign victim_dirty = valid_q[index] && dirty_q[index];

    assign wb_done     = (state_q == PS_WRITEBACK) && i_mem_rsp.ack;
    assign refill_done = (state_q == PS_REFILL) && i_mem_rsp.ack;

    // Miss FSM.
    always_comb begin
        state_d = state_q;
        case (state_q)
            PS_LOOKUP: begin
                if (lookup_go && !hit) begin
                    if (victim_dirty) begin
                        state_d = PS_WRITEBACK;
                    end else begin
                        state_d = PS_REFILL;
                    end
                end
            end
            PS_WRITEBACK: begin
                if (i_mem_rsp.ack) begin
                    state_d = PS_REFILL;  // Old line is safe in memory.
                end
            end
            PS_REFILL: begin
                if (i_mem_rsp.ack) begin
                    state_d = PS_LOOKUP;  // Retry hits next cycle.
                end
            end
            default: begin
                state_d = PS_LOOKUP;
            end
        endcase
    end

    always_ff @(posedge Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= PS_LOOKUP;
            valid_q    <= '0;
            dirty_q    <= '0;
            o_cpu_done <= 1'b0;
        end else begin
            state_q    <= state_d;
            o_cpu_done <= lookup_go && hit;
            if (lookup_go && hit && i_cpu_req.write) begin
                dirty_q[index] <= 1'b1;
            end
            if (wb_done) begin
                dirty_q[index] <= 1'b0;
            end
            if (refill_done) begin
                valid_q[index] <= 1'b1;
                dirty_q[index] <= 1'b0;  // Fresh line is clean.
            end
        end
    end

    // Line data, tags and the read word.
    always_ff @(posedge Clk) begin
        if (lookup_go && hit) begin
            if (i_cpu_req.write) begin
                data_q[index][offset] <= i_cpu_req.wdata;
            end
            if (i_cpu_req.read) begin
                o_cpu_rdata <= data_q[index][offset];
            end
        end
        if (refill_done) begin
            data_q[index] <= i_mem_rsp.rdata;
            tag_q[index]  <= tag;
        end
    end

    // Write-back names the victim, refill names the requested line.
    always_comb begin
        o_mem_req.valid           = (state_q == PS_WRITEBACK) || (state_q == PS_REFILL);
        o_mem_req.op              = (state_q == PS_WRITEBACK) ? MEM_WRITE : MEM_READ;
        o_mem_req.line_addr.index = index;
        o_mem_req.line_addr.tag   = (state_q == PS_WRITEBACK) ? tag_q[index] : tag;
        o_mem_req.wdata           = data_q[index];
    end

    property p_done_has_req;
        @(posedge Clk) disable iff (!i_rst_n)
            $rose(o_cpu_done) |-> (i_cpu_req.read || i_cpu_req.write);
    endproperty

    a_done_has_req: assert property (p_done_has_req)
        else $error("cache_port: done without a CPU request.");

    property p_mem_req_stable;
        @(posedge Clk) disable iff (!i_rst_n)
            (o_mem_req.valid && !i_mem_rsp.ack) |=> $stable(o_mem_req);
    endproperty

    a_mem_req_stable: assert property (p_mem_req_stable)
        else $error("cache_port: memory request changed before ack.");

endmodule

//--- source/mem_arbiter.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module mem_arbiter import cache_pkg::*; (
    input  logic     Clk,
    input  logic     i_rst_n,
    input  mem_req_t i_port_req [`CACHE_PORTS],
    output mem_rsp_t o_port_rsp [`CACHE_PORTS],
    output mem_req_t o_mem_req,
    input  mem_rsp_t i_mem_rsp
);

    localparam int port_w = $clog2(`CACHE_PORTS);

    typedef logic [port_w-1:0] port_idx_t;

    logic      busy_q;
    logic      gap_q;  // Valid stays low for the cycle after an ack.
    port_idx_t grant_q;
    port_idx_t last_q;
    port_idx_t pick;
    port_idx_t cand;
    port_idx_t sel;
    logic      pick_valid;

    // Round-robin search from the port after the last served one.
    always_comb begin
        pick_valid = 1'b0;
        pick       = last_q;
        cand       = last_q;
        for (int n = 1; n <= `CACHE_PORTS; n++) begin
            cand = port_idx_t'((int'(last_q) + n) % `CACHE_PORTS);
            if (!pick_valid && i_port_req[cand].valid) begin
                pick_valid = 1'b1;
                pick       = cand;
            end
        end
    end

    // Grant is locked while busy; when idle the pick goes straight out.
    assign sel = busy_q ? grant_q : pick;

    always_comb begin
        o_mem_req       = i_port_req[sel];
        o_mem_req.valid = i_port_req[sel].valid && !gap_q;
    end

    // Ack and line data go to the selected port only.
    always_comb begin
        for (int p = 0; p < `CACHE_PORTS; p++) begin
            o_port_rsp[p] = '0;
            if (port_idx_t'(p) == sel) begin
                o_port_rsp[p] = i_mem_rsp;
            end
        end
    end

    always_ff @(posedge Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q  <= 1'b0;
            gap_q   <= 1'b0;
            grant_q <= '0;
            last_q  <= port_idx_t'(`CACHE_PORTS - 1);  // Port 0 wins the first tie.
        end else begin
            gap_q <= i_mem_rsp.ack;
            if (i_mem_rsp.ack) begin
                busy_q <= 1'b0;
                last_q <= sel;
            end else if (!busy_q && !gap_q && pick_valid) begin
                busy_q  <= 1'b1;
                grant_q <= pick;
            end
        end
    end

    property p_ack_with_req;
        @(posedge Clk) disable iff (!i_rst_n)
            i_mem_rsp.ack |-> o_mem_req.valid;
    endproperty

    a_ack_with_req: assert property (p_ack_with_req)
        else $error("mem_arbiter: ack without a valid request.");

    property p_grant_locked;
        @(posedge Clk) disable iff (!i_rst_n)
            (o_mem_req.valid && !i_mem_rsp.ack) |=> (sel == $past(sel));
    endproperty

    a_grant_locked: assert property (p_grant_locked)
        else $error("mem_arbiter: grant moved while busy.");

endmodule

//--- source/split_cache_top.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module split_cache_top import cache_pkg::*; (
    input  logic                    Clk,
    input  logic                    i_rst_n,
    input  cpu_req_t                i_cpu_req   [`CACHE_PORTS],
    output word_t                   o_cpu_rdata [`CACHE_PORTS],
    output logic [`CACHE_PORTS-1:0] o_cpu_done,
    output mem_req_t                o_mem_req,
    input  mem_rsp_t                i_mem_rsp
);

    // Line traffic between the cache ports and the arbiter.
    mem_req_t port_req [`CACHE_PORTS];
    mem_rsp_t port_rsp [`CACHE_PORTS];

    // Port 0 serves instructions, port 1 data.
    for (genvar p = 0; p < `CACHE_PORTS; p++) begin : g_port
        cache_port cache_port_i (
            .Clk         (Clk),
            .i_rst_n     (i_rst_n),
            .i_cpu_req   (i_cpu_req[p]),
            .o_cpu_rdata (o_cpu_rdata[p]),
            .o_cpu_done  (o_cpu_done[p]),
            .o_mem_req   (port_req[p]),
            .i_mem_rsp   (port_rsp[p])
        );
    end

    // One shared line bus to memory.
    mem_arbiter mem_arbiter_i (
        .Clk        (Clk),
        .i_rst_n    (i_rst_n),
        .i_port_req (port_req),
        .o_port_rsp (port_rsp),
        .o_mem_req  (o_mem_req),
        .i_mem_rsp  (i_mem_rsp)
    );

endmodule

//--- verification/tb_split_cache.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module tb_split_cache import cache_pkg::*; ();

    localparam int num_req      = 400;
    localparam int reset_cycles = 16;
    localparam int watchdog_ns  = (reset_cycles + num_req * 3 * 12) * 10;

    logic                    Clk = 1'b0;
    logic                    i_rst_n = 1'b0;
    cpu_req_t                i_cpu_req [`CACHE_PORTS] = '{default: '0};
    word_t                   o_cpu_rdata [`CACHE_PORTS];
    logic [`CACHE_PORTS-1:0] o_cpu_done;
    mem_req_t                o_mem_req;
    mem_rsp_t                i_mem_rsp = '0;

    logic [31:0] lfsr = 32'hb885;
    int          cycle = 0;

    word_t mem    [0:65535];  // Backing memory behind the bus.
    word_t golden [0:65535];  // Memory as the CPU should see it.

    // Cache model, one copy per port.
    tag_t mtag   [`CACHE_PORTS][`CACHE_LINES];
    bit   mvalid [`CACHE_PORTS][`CACHE_LINES];
    bit   mdirty [`CACHE_PORTS][`CACHE_LINES];

    mem_req_t exp_q [`CACHE_PORTS][$];  // Predicted bus traffic per port.
    bit       busy [`CACHE_PORTS];
    bit       exp_hit [`CACHE_PORTS];
    bit       exp_read [`CACHE_PORTS];
    word_t    exp_rdata [`CACHE_PORTS];
    int       issue_cycle [`CACHE_PORTS];
    int       sent [`CACHE_PORTS];
    int       completed [`CACHE_PORTS];

    bit       mem_pending;
    bit       gap_due;
    int       mem_wait;
    int       mem_port;
    int       last_port = `CACHE_PORTS - 1;
    mem_req_t held_req;

    split_cache_top split_cache_top_i (
        .Clk         (Clk),
        .i_rst_n     (i_rst_n),
        .i_cpu_req   (i_cpu_req),
        .o_cpu_rdata (o_cpu_rdata),
        .o_cpu_done  (o_cpu_done),
        .o_mem_req   (o_mem_req),
        .i_mem_rsp   (i_mem_rsp)
    );

    always #5 Clk = ~Clk;

    function automatic word_t fill_word(logic [15:0] a);
        return a ^ {a[6:0], a[15:7]} ^ 16'hc3a5;
    endfunction

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // A port has its bus request up from the cycle after its lookup edge.
    function automatic bit port_waiting(int p);
        return (exp_q[p].size() != 0) && (cycle - issue_cycle[p] >= 2);
    endfunction

    task automatic report_mismatch(string name, string expected, string actual);
        $display("Fail at time %0t: %s expected %s, got %s", $time, name, expected, actual);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic report_error(string what);
        $display("Error at time %0t: %s", $time, what);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic issue_request(int p);
        cpu_req_t req;
        index_t   idx;
        mem_req_t m;
        req = '0;
        req.addr.tag    = {(p == 0), 8'h00, 2'(rand_bits(2))};  // Few tags per index.
        req.addr.index  = index_t'(rand_bits(3));
        req.addr.offset = offset_t'(rand_bits(2));
        req.write       = (p != 0) && (rand_bits(1) == 1);
        req.read        = !req.write;
        req.wdata       = word_t'(rand_bits(16));
        idx = req.addr.index;
        exp_hit[p] = mvalid[p][idx] && (mtag[p][idx] == req.addr.tag);
        if (!exp_hit[p]) begin
            if (mvalid[p][idx] && mdirty[p][idx]) begin
                m = '0;
                m.valid     = 1'b1;
                m.op        = MEM_WRITE;
                m.line_addr = {mtag[p][idx], idx};
                for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
                    m.wdata[w] = golden[{mtag[p][idx], idx, 2'(w)}];
                end
                exp_q[p].push_back(m);
            end
            m = '0;
            m.valid     = 1'b1;
            m.op        = MEM_READ;
            m.line_addr = {req.addr.tag, idx};
            exp_q[p].push_back(m);
            mvalid[p][idx] = 1'b1;
            mtag[p][idx]   = req.addr.tag;
            mdirty[p][idx] = 1'b0;
        end
        if (req.write) begin
            golden[req.addr] = req.wdata;
            mdirty[p][idx]   = 1'b1;
        end
        exp_read[p]    = req.read;
        exp_rdata[p]   = golden[req.addr];
        busy[p]        = 1'b1;
        issue_cycle[p] = cycle;
        sent[p]++;
        i_cpu_req[p] <= req;
    endtask

    task automatic drive_port(int p);
        if (o_cpu_done[p]) begin
            assert (busy[p])
                else report_error($sformatf("Port %0d signalled done with no request.", p));
            assert (exp_q[p].size() == 0)
                else report_error($sformatf("Port %0d finished before its bus traffic.", p));
            if (exp_hit[p]) begin
                assert (cycle - issue_cycle[p] == 2)
                    else report_error($sformatf("Hit on port %0d took %0d cycles.", p,
                                                cycle - issue_cycle[p] - 1));
            end
            if (exp_read[p]) begin
                assert (o_cpu_rdata[p] == exp_rdata[p])
                    else report_mismatch($sformatf("o_cpu_rdata[%0d]", p),
                                         $sformatf("%h", exp_rdata[p]),
                                         $sformatf("%h", o_cpu_rdata[p]));
            end
            busy[p] = 1'b0;
            completed[p]++;
            i_cpu_req[p] <= '0;
        end
        if (!busy[p] && sent[p] < num_req && rand_bits(2) != 0) begin
            issue_request(p);  // Some idle cycles vary the tie timing.
        end
    endtask

    task automatic start_transfer();
        int       p;
        mem_req_t head;
        p = o_mem_req.line_addr.tag[`CACHE_TAG_W-1] ? 0 : 1;  // Region bit names the port.
        assert (port_waiting(p))
            else report_error($sformatf("Port %0d sent a bus request with no predicted miss.", p));
        if (port_waiting(0) && port_waiting(1)) begin
            assert (p != last_port)
                else report_error($sformatf("Port %0d won a tie but was served last.", p));
        end
        head = exp_q[p][0];
        assert ({o_mem_req.op, o_mem_req.line_addr} == {head.op, head.line_addr})
            else report_mismatch("o_mem_req.op/line_addr",
                                 $sformatf("%h", {head.op, head.line_addr}),
                                 $sformatf("%h", {o_mem_req.op, o_mem_req.line_addr}));
        if (head.op == MEM_WRITE) begin
            assert (o_mem_req.wdata == head.wdata)
                else report_mismatch("o_mem_req.wdata", $sformatf("%h", head.wdata),
                                     $sformatf("%h", o_mem_req.wdata));
        end
        held_req    = o_mem_req;
        mem_port    = p;
        mem_pending = 1'b1;
        mem_wait    = int'(rand_bits(3));  // 1 to 8 cycles to the ack.
    endtask

    task automatic serve_transfer();
        mem_rsp_t rsp;
        rsp = '0;
        for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
            if (held_req.op == MEM_WRITE) begin
                mem[{held_req.line_addr, 2'(w)}] = held_req.wdata[w];
            end else begin
                rsp.rdata[w] = mem[{held_req.line_addr, 2'(w)}];
            end
        end
        rsp.ack = 1'b1;
        i_mem_rsp <= rsp;
        void'(exp_q[mem_port].pop_front());
        last_port   = mem_port;
        mem_pending = 1'b0;
    endtask

    task automatic watch_memory();
        if (i_mem_rsp.ack) begin
            i_mem_rsp <= '0;
            gap_due = 1'b1;
        end else if (gap_due) begin
            gap_due = 1'b0;
            assert (!o_mem_req.valid)
                else report_error("Bus request stayed valid in the cycle after an ack.");
        end else if (o_mem_req.valid) begin
            if (!mem_pending) begin
                start_transfer();
            end else begin
                assert (o_mem_req == held_req)
                    else report_mismatch("o_mem_req", $sformatf("%h", held_req),
                                         $sformatf("%h", o_mem_req));
            end
            if (mem_wait == 0) begin
                serve_transfer();
            end else begin
                mem_wait--;
            end
        end
    endtask

    task automatic finish_run();
        if (mem_pending || i_mem_rsp.ack || exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            report_error("Bus traffic was still due when all requests had completed.");
        end else begin
            $display("Regression passed");
            $finish;
        end
    endtask

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a]    = fill_word(16'(a));
            golden[a] = mem[a];
        end
        repeat (reset_cycles) @(posedge Clk);
        i_rst_n <= 1'b1;
    end

    always @(posedge Clk) begin
        cycle++;
        if (!i_rst_n) begin
            assert (o_cpu_done == '0)
                else report_mismatch("o_cpu_done", "0", $sformatf("%b", o_cpu_done));
            assert (!o_mem_req.valid)
                else report_mismatch("o_mem_req.valid", "0", "1");
        end else begin
            watch_memory();
            for (int p = 0; p < `CACHE_PORTS; p++) begin
                drive_port(p);
            end
            if (completed[0] == num_req && completed[1] == num_req) begin
                finish_run();
            end
        end
    end

    // Watchdog.
    initial begin
        #(watchdog_ns);
        $display("The run timed out after %0d ns before all requests completed.", watchdog_ns);
        $display("Regression failed");
        $fatal(1, "Watchdog expired.");
    end

endmodule
